//--- tb.f
+incdir+include
design/uartPkg.sv
design/byteFifoIf.sv
design/baudTickGen.sv
design/uartReceiver.sv
design/uartTransmitter.sv
design/byteFifo.sv
design/wbUartRegs.sv
design/uartCore.sv
bench/tbClock.sv
bench/uartTb.sv

//--- bench/uartTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uartTb import uartPkg::*; ();

    localparam int depth      = `UART_FIFO_DEPTH;
    localparam int maxDiv     = 6;
    localparam int maxFrames  = (depth - 1) + (depth + 5) + (depth + 3);
    localparam int cycleLimit = maxFrames * 10 * 16 * maxDiv + 20000; // frames plus slack

    logic                      clk, rstN;
    logic                      cyc, stb, we, rxd, ack, txd;
    logic [1:0]                adr;
    logic [`UART_WB_WIDTH-1:0] datIn, datOut;

    uartByte     expRx[$];
    uartByte     expTx[$];
    uartByte     txSeen[$];
    int          divModel;
    logic        overrunModel;
    int          testErrors = 0;
    int          passCount  = 0;
    int          failCount  = 0;
    int          cycleCount = 0;
    logic [31:0] seed;

    tbClock i_clock (.clk(clk), .rstN(rstN));

    uartCore i_dut (
        .clk    (clk),
        .rstN   (rstN),
        .cyc    (cyc),
        .stb    (stb),
        .we     (we),
        .adr    (adr),
        .datIn  (datIn),
        .rxd    (rxd),
        .datOut (datOut),
        .ack    (ack),
        .txd    (txd)
    );

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > cycleLimit) begin
            $display("run stopped: tests did not finish within %0d cycles", cycleLimit);
            $display("Testbench failed");
            $finish;
        end
    end

    // ########################################################################
    // reporting and bus tasks
    // ########################################################################

    task automatic reportError(input string msg);
        $display("** Error at %0t: %s", $time, msg);
        testErrors++;
    endtask

    task automatic endTest(input string name);
        if (testErrors == 0) begin
            $display("test %-24s ok", name);
            passCount++;
        end
        else begin
            $display("test %-24s %0d error(s)", name, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    task automatic busCycle(input logic write, input logic [1:0] a,
                            input logic [15:0] wdata, output logic [15:0] rdata);
        int waitCount;
        waitCount = 0;
        @(posedge clk);
        cyc   <= 1'b1;
        stb   <= 1'b1;
        we    <= write;
        adr   <= a;
        datIn <= wdata;
        do begin
            @(posedge clk);
            waitCount++;
        end while (!ack && waitCount < 16);
        rdata = datOut; // value before the pop at this edge
        cyc <= 1'b0;
        stb <= 1'b0;
        we  <= 1'b0;
        if (!ack) begin
            $display("bus transfer to address %0d got no ack within 16 cycles", a);
            testErrors++;
        end
    endtask

    task automatic busRead(input logic [1:0] a, output logic [15:0] rdata);
        busCycle(1'b0, a, 16'h0000, rdata);
    endtask

    task automatic busWrite(input logic [1:0] a, input logic [15:0] wdata);
        logic [15:0] unused;
        busCycle(1'b1, a, wdata, unused);
    endtask

    task automatic readStatus(output logic [15:0] rd);
        busRead(regStatus, rd);
        if (rd[4] !== overrunModel) begin
            reportError($sformatf("overrun is %b, model has %b", rd[4], overrunModel));
        end
        overrunModel = 1'b0; // cleared by the read
    endtask

    // ########################################################################
    // serial line model
    // ########################################################################

    task automatic sendFrame(input uartByte b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0}; // stop, data, start
        for (int i = 0; i < 10; i++) begin
            rxd <= frame[i];
            repeat (16 * divModel) @(posedge clk);
        end
        if (expRx.size() < depth) begin
            expRx.push_back(b);
        end
        else begin
            overrunModel = 1'b1;
        end
    endtask

    always begin : txMonitor
        uartByte b;
        @(negedge txd);
        repeat (8 * divModel) @(posedge clk); // mid start bit
        if (txd !== 1'b0) begin
            reportError("start bit on txd did not last to mid-bit");
        end
        for (int i = 0; i < `UART_DATA_WIDTH; i++) begin
            repeat (16 * divModel) @(posedge clk);
            b[i] = txd;
        end
        repeat (16 * divModel) @(posedge clk);
        if (txd !== 1'b1) begin
            reportError("stop bit on txd is low");
        end
        txSeen.push_back(b);
    end

    // ########################################################################
    // tests
    // ########################################################################

    initial begin
        logic [15:0] rd;
        uartByte     b;
        uartByte     got;
        int          n;

        cyc          <= 1'b0;
        stb          <= 1'b0;
        we           <= 1'b0;
        adr          <= 2'd0;
        datIn        <= '0;
        rxd          <= 1'b1;
        divModel     = `UART_RESET_DIVISOR;
        overrunModel = 1'b0;
        seed         = 32'h8a6a_cb9a;
        void'($urandom(seed));
        @(posedge rstN);
        @(posedge clk);

        readStatus(rd);
        if (rd[0] !== 1'b0 || rd[3] !== 1'b1 || rd[5] !== 1'b1) begin
            reportError($sformatf("status after reset is %h", rd));
        end
        busRead(regDivisor, rd);
        if (rd !== 16'(`UART_RESET_DIVISOR)) begin
            reportError($sformatf("divisor after reset is %0d", rd));
        end
        endTest("reset values");

        divModel = 2 + ($urandom % 5);
        busWrite(regDivisor, 16'(divModel));
        busRead(regDivisor, rd);
        if (rd !== 16'(divModel)) begin
            reportError($sformatf("divisor reads %0d, wrote %0d", rd, divModel));
        end
        endTest("divisor write");

        n = 1 + ($urandom % (depth - 1));
        for (int i = 0; i < n; i++) begin
            sendFrame(8'($urandom));
        end
        while (expRx.size() > 0) begin
            b = expRx.pop_front();
            busRead(regData, rd);
            if (rd !== {8'h00, b}) begin
                reportError($sformatf("rx data %h, expected %h", rd, b));
            end
        end
        readStatus(rd);
        if (rd[0] !== 1'b0) begin
            reportError("rxAvailable still set after last byte");
        end
        busRead(regData, rd);
        if (rd !== 16'h0000) begin
            reportError($sformatf("read of empty rx FIFO gives %h", rd));
        end
        endTest("receive path");

        n = depth + 2 + ($urandom % 4); // enough to fill the tx FIFO
        for (int i = 0; i < n; i++) begin
            do begin
                readStatus(rd);
            end while (rd[2]);
            b = 8'($urandom);
            busWrite(regData, {8'h00, b});
            expTx.push_back(b);
        end
        while (txSeen.size() < n) begin
            @(posedge clk);
        end
        while (expTx.size() > 0) begin
            b   = expTx.pop_front();
            got = txSeen.pop_front();
            if (got !== b) begin
                reportError($sformatf("txd carried %h, expected %h", got, b));
            end
        end
        do begin
            readStatus(rd);
        end while (!rd[3]);
        endTest("transmit path");

        for (int i = 0; i < depth + 3; i++) begin
            sendFrame(8'($urandom));
        end
        readStatus(rd); // overrun set, checked against the model
        if (rd[1] !== 1'b1) begin
            reportError("rxFull not set with a full rx FIFO");
        end
        readStatus(rd);
        while (expRx.size() > 0) begin
            b = expRx.pop_front();
            busRead(regData, rd);
            if (rd !== {8'h00, b}) begin
                reportError($sformatf("rx data %h after overrun, expected %h", rd, b));
            end
        end
        endTest("rx overrun");

        for (int i = 0; i < 4; i++) begin
            rxd <= 1'b0;
            repeat (1 + ($urandom % (4 * divModel - 1))) @(posedge clk); // under a quarter bit
            rxd <= 1'b1;
            repeat (16 * divModel) @(posedge clk);
        end
        readStatus(rd);
        if (rd[0] !== 1'b0 || rd[5] !== 1'b1) begin
            reportError($sformatf("status after glitches is %h", rd));
        end
        endTest("glitch rejection");

        $display("tests passed: %0d, tests failed: %0d", passCount, failCount);
        if (failCount == 0) begin
            $display("Testbench passed");
        end
        else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/tbClock.sv
`timescale 1ns/1ps
`default_nettype none

module tbClock #(
    parameter int resetCycles = 5
) (
    output logic clk,
    output logic rstN
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk; // 10 ns period
    end

    initial begin
        rstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

//--- design/uartCore.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uartCore (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [1:0]                adr,
    input  logic [`UART_WB_WIDTH-1:0] datIn,
    input  logic                      rxd,
    output logic [`UART_WB_WIDTH-1:0] datOut,
    output logic                      ack,
    output logic                      txd
);

    logic [15:0] divisor;
    logic        baudTick;
    logic        rxIdle;
    logic        txIdle;

    byteFifoIf rxFifoBus ();
    byteFifoIf txFifoBus ();

    baudTickGen i_baudTickGen (
        .clk      (clk),
        .rstN     (rstN),
        .divisor  (divisor),
        .baudTick (baudTick)
    );

    uartReceiver i_uartReceiver (
        .clk      (clk),
        .rstN     (rstN),
        .rxd      (rxd),
        .baudTick (baudTick),
        .rxIdle   (rxIdle),
        .rxOut    (rxFifoBus.writer)
    );

    uartTransmitter i_uartTransmitter (
        .clk      (clk),
        .rstN     (rstN),
        .baudTick (baudTick),
        .txd      (txd),
        .txIdle   (txIdle),
        .txIn     (txFifoBus.reader)
    );

    byteFifo #(.depth(`UART_FIFO_DEPTH)) i_rxFifo (
        .clk  (clk),
        .rstN (rstN),
        .port (rxFifoBus.store)
    );

    byteFifo #(.depth(`UART_FIFO_DEPTH)) i_txFifo (
        .clk  (clk),
        .rstN (rstN),
        .port (txFifoBus.store)
    );

    wbUartRegs i_wbUartRegs (
        .clk     (clk),
        .rstN    (rstN),
        .cyc     (cyc),
        .stb     (stb),
        .we      (we),
        .adr     (adr),
        .datIn   (datIn),
        .datOut  (datOut),
        .ack     (ack),
        .rxIdle  (rxIdle),
        .txIdle  (txIdle),
        .divisor (divisor),
        .rxIn    (rxFifoBus.reader),
        .txOut   (txFifoBus.writer)
    );

endmodule

`default_nettype wire

//--- design/wbUartRegs.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module wbUartRegs import uartPkg::*; (
    input  logic                      clk,
    input  logic                      rstN,
    input  logic                      cyc,
    input  logic                      stb,
    input  logic                      we,
    input  logic [1:0]                adr,
    input  logic [`UART_WB_WIDTH-1:0] datIn,
    output logic [`UART_WB_WIDTH-1:0] datOut,
    output logic                      ack,
    input  logic                      rxIdle,
    input  logic                      txIdle,
    output logic [15:0]               divisor,
    byteFifoIf.reader                 rxIn,
    byteFifoIf.writer                 txOut
);

    regAddr addr;
    logic   xfer;
    logic   statusRead;
    logic   overrun;
    logic   txAllIdle;

    assign addr = regAddr'(adr);
    assign xfer = ack && cyc && stb; // side effects only here

    assign statusRead = xfer && !we && (addr == regStatus);
    assign txAllIdle  = txOut.empty && txIdle;

    assign txOut.push     = xfer && we && (addr == regData);
    assign txOut.pushData = datIn[`UART_DATA_WIDTH-1:0];
    assign rxIn.pop       = xfer && !we && (addr == regData) && !rxIn.empty;

    // ##########################################################################
    // handshake and registers
    // ##########################################################################

    always_ff @(posedge clk) begin
        if (!rstN) begin
            ack     <= 1'b0;
            overrun <= 1'b0;
            divisor <= 16'(`UART_RESET_DIVISOR);
        end
        else begin
            ack <= cyc && stb && !ack; // single-cycle, gap between transfers
            if (statusRead) begin
                overrun <= 1'b0;
            end
            if (rxIn.dropped) begin
                overrun <= 1'b1; // set wins over the clear
            end
            if (xfer && we && (addr == regDivisor)) begin
                divisor <= (datIn == '0) ? 16'd1 : datIn[15:0]; // never zero
            end
        end
    end

    // ##########################################################################
    // read mux
    // ##########################################################################

    always_comb begin
        datOut = '0;
        case (addr)
            regData: begin
                if (!rxIn.empty) begin
                    datOut[`UART_DATA_WIDTH-1:0] = rxIn.popData;
                end
            end
            regStatus: begin
                datOut[0] = !rxIn.empty; // rxAvailable
                datOut[1] = rxIn.full;
                datOut[2] = txOut.full;
                datOut[3] = txAllIdle;
                datOut[4] = overrun;
                datOut[5] = rxIdle;
            end
            regDivisor: datOut[15:0] = divisor;
            default:    datOut = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- design/byteFifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module byteFifo import uartPkg::*; #(
    parameter int depth = `UART_FIFO_DEPTH
) (
    input  logic     clk,
    input  logic     rstN,
    byteFifoIf.store port
);

    localparam int ptrWidth = $clog2(depth);
    localparam int cntWidth = $clog2(depth + 1);

    uartByte             mem [depth];
    logic [ptrWidth-1:0] rdPtr, wrPtr;
    logic [cntWidth-1:0] count;
    logic                doPush, doPop;

    assign port.full    = (count == cntWidth'(depth));
    assign port.empty   = (count == '0);
    assign port.popData = mem[rdPtr]; // show-ahead head
    assign port.dropped = port.push && port.full;

    assign doPush = port.push && !port.full;
    assign doPop  = port.pop && !port.empty;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end
        else begin
            if (doPush) begin
                wrPtr <= wrPtr + ptrWidth'(1); // wraps, depth is 2**n
            end
            if (doPop) begin
                rdPtr <= rdPtr + ptrWidth'(1);
            end
            if (doPush && !doPop) begin
                count <= count + cntWidth'(1);
            end
            else if (doPop && !doPush) begin
                count <= count - cntWidth'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (doPush) begin
            mem[wrPtr] <= port.pushData;
        end
    end

endmodule

`default_nettype wire

//--- design/uartTransmitter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uartTransmitter import uartPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      baudTick,
    output logic      txd,
    output logic      txIdle,
    byteFifoIf.reader txIn
);

    localparam int countWidth = $clog2(`UART_DATA_WIDTH);

    txState                currentState, nextState;
    logic [countWidth-1:0] currentCount, nextCount;
    logic [3:0]            currentTick, nextTick;
    uartByte               currentShift, nextShift;
    logic                  nextTxd;

    assign txIn.pop = (currentState == txsIdle) && !txIn.empty;
    assign txIdle   = (currentState == txsIdle);

    always_ff @(posedge clk) begin
        if (!rstN) begin
            currentState <= txsIdle;
            currentCount <= '0;
            currentTick  <= 4'd0;
            txd          <= 1'b1; // line idles high
        end
        else begin
            currentState <= nextState;
            currentCount <= nextCount;
            currentTick  <= nextTick;
            txd          <= nextTxd;
        end
    end

    always_ff @(posedge clk) begin
        currentShift <= nextShift;
    end

    always_comb begin
        nextState = currentState;
        nextCount = currentCount;
        nextTick  = currentTick;
        nextShift = currentShift;

        case (currentState)
            txsIdle: begin
                if (txIn.pop) begin
                    nextShift = txIn.popData;
                    nextTick  = 4'd0; // bit timing starts at the pop
                    nextCount = '0;
                    nextState = txsStart;
                end
            end

            txsStart: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd15) begin
                        nextState = txsDataSend;
                    end
                end
            end

            txsDataSend: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd15) begin
                        nextShift = currentShift >> 1;
                        nextCount = currentCount + countWidth'(1);
                        if (currentCount == countWidth'(`UART_DATA_WIDTH - 1)) begin
                            nextState = txsStop;
                        end
                    end
                end
            end

            txsStop: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd15) begin
                        nextState = txsIdle;
                    end
                end
            end

            default: nextState = txsIdle;
        endcase

        // line level follows the state being entered
        case (nextState)
            txsStart:    nextTxd = 1'b0;
            txsDataSend: nextTxd = nextShift[0];
            default:     nextTxd = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- design/uartReceiver.sv
`timescale 1ns/1ps
`default_nettype none

`include "uart_settings.svh"

module uartReceiver import uartPkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      rxd,
    input  logic      baudTick,
    output logic      rxIdle,
    byteFifoIf.writer rxOut
);

    localparam int countWidth = $clog2(`UART_DATA_WIDTH);

    rxState                currentState, nextState;
    logic [countWidth-1:0] currentCount, nextCount;
    logic [3:0]            currentTick, nextTick;
    uartByte               currentData, nextData;
    logic                  rxdMeta, rxdSync;

    // two-flop synchroniser, idles high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            rxdMeta <= 1'b1;
            rxdSync <= 1'b1;
        end
        else begin
            rxdMeta <= rxd;
            rxdSync <= rxdMeta;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            currentState <= rxsIdle;
            currentCount <= '0;
            currentTick  <= 4'd0;
        end
        else begin
            currentState <= nextState;
            currentCount <= nextCount;
            currentTick  <= nextTick;
        end
    end

    always_ff @(posedge clk) begin
        currentData <= nextData;
    end

    always_comb begin
        nextState = currentState;
        nextCount = currentCount;
        nextTick  = currentTick;
        nextData  = currentData;

        case (currentState)
            rxsIdle: begin
                nextTick  = 4'd0;
                nextCount = '0;
                if (!rxdSync) begin
                    nextState = rxsStart;
                end
            end

            rxsStart: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd7) begin // middle of start bit
                        if (!rxdSync) begin
                            nextState = rxsDataReceive;
                            nextCount = '0;
                            nextTick  = 4'd0;
                        end
                        else begin
                            nextState = rxsIdle; // glitch
                        end
                    end
                end
            end

            rxsDataReceive: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd15) begin
                        nextData  = {rxdSync, currentData[`UART_DATA_WIDTH-1:1]}; // lsb first
                        nextCount = currentCount + countWidth'(1);
                        if (currentCount == countWidth'(`UART_DATA_WIDTH - 1)) begin
                            nextState = rxsStop;
                        end
                    end
                end
            end

            rxsStop: begin
                if (baudTick) begin
                    nextTick = currentTick + 4'd1;
                    if (currentTick == 4'd15) begin
                        nextState = rxsIdle;
                    end
                end
            end

            default: nextState = rxsIdle;
        endcase
    end

    assign rxOut.push     = (currentState == rxsStop) && (nextState == rxsIdle);
    assign rxOut.pushData = currentData;
    assign rxIdle         = (currentState == rxsIdle);

endmodule

`default_nettype wire

//--- design/baudTickGen.sv
`timescale 1ns/1ps
`default_nettype none

module baudTickGen (
    input  logic        clk,
    input  logic        rstN,
    input  logic [15:0] divisor,
    output logic        baudTick
);

    logic [15:0] count;

    assign baudTick = (count == 16'd0); // one clk per reload

    always_ff @(posedge clk) begin
        if (!rstN) begin
            count <= 16'd0;
        end
        else if (baudTick) begin
            count <= divisor - 16'd1; // new divisor picked up here
        end
        else begin
            count <= count - 16'd1;
        end
    end

endmodule

`default_nettype wire

//--- design/byteFifoIf.sv
`timescale 1ns/1ps
`default_nettype none

interface byteFifoIf import uartPkg::*; ();

    logic    push;
    uartByte pushData;
    logic    full;
    logic    pop;
    uartByte popData;
    logic    empty;
    logic    dropped; // push met a full FIFO

    modport writer (output push, pushData, input full, empty, dropped);

    modport reader (output pop, input popData, empty, full, dropped);

    modport store (
        input  push, pushData, pop,
        output full, popData, empty, dropped
    );

endinterface

`default_nettype wire

//--- design/uartPkg.sv
`default_nettype none

`include "uart_settings.svh"

package uartPkg;

    typedef logic [`UART_DATA_WIDTH-1:0] uartByte;

    // receiver FSM
    typedef enum logic [1:0] {
        rxsIdle        = 2'd0,
        rxsStart       = 2'd1,
        rxsDataReceive = 2'd2,
        rxsStop        = 2'd3
    } rxState;

    // transmitter FSM
    typedef enum logic [1:0] {
        txsIdle     = 2'd0,
        txsStart    = 2'd1,
        txsDataSend = 2'd2,
        txsStop     = 2'd3
    } txState;

    // word addresses on the bus
    typedef enum logic [1:0] {
        regData    = 2'd0,
        regStatus  = 2'd1,
        regDivisor = 2'd2,
        regUnused  = 2'd3
    } regAddr;

endpackage

`default_nettype wire

//--- include/uart_settings.svh
`ifndef UART_SETTINGS_SVH
`define UART_SETTINGS_SVH

// ##########################################################################
// frame and buffer sizes
// ##########################################################################

`define UART_DATA_WIDTH 8 // bits per character
`define UART_FIFO_DEPTH 8 // power of two

// ##########################################################################
// bus side
// ##########################################################################

`define UART_WB_WIDTH      16
`define UART_RESET_DIVISOR 4 // clk per oversampling tick

`endif
